/* verilog/serv_cfg_pkg.sv */
package serv_cfg_pkg;

   // ------------------------------------------------------------------------
   // datapath sizes
   // ------------------------------------------------------------------------

   // data and address width of the core.
   localparam int XLEN = 32;

   // width of the serial bit counter, enough to count one word.
   localparam int CNT_W = 5;

   // ------------------------------------------------------------------------
   // reset state
   // ------------------------------------------------------------------------

   // first instruction address fetched after reset.
   localparam logic [XLEN-1:0] RESET_PC = 32'd8;

endpackage

/* verilog/serv_seq_pkg.sv */
package serv_seq_pkg;

   // count value of the final serial bit of a pass.
   localparam int LAST_CNT = 31;

   // bit index where the constant 4 is injected into the pc adder.
   localparam int PLUS4_BIT = 2;

   // target bit that is sampled for the misalignment flag.
   localparam int MISALIGN_BIT = 1;

endpackage

/* verilog/ser_add.sv */
`timescale 1ns/1ps

module ser_add (
   input  logic clk,
   input  logic i_rst,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q
);

   logic carry;
   logic carry_next;

   // sum bit is combinational, the carry moves on to the next bit position.
   assign o_q        = i_a ^ i_b ^ carry;
   assign carry_next = (i_a & i_b) | (i_a & carry) | (i_b & carry);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry <= 1'b0;
      end else if (i_clr) begin
         // start of a new word.
         carry <= 1'b0;
      end else begin
         carry <= carry_next;
      end
   end

endmodule

/* verilog/shift_reg.sv */
`timescale 1ns/1ps

module shift_reg import serv_cfg_pkg::*; #(
   parameter int              LEN  = XLEN,
   parameter logic [LEN-1:0] INIT = '0
) (
   input  logic           clk,
   input  logic           i_rst,
   input  logic           i_en,
   input  logic           i_d,
   output logic           o_q,
   output logic [LEN-2:0] o_par
);

   logic [LEN-1:0] data;

   // new bits enter at the top and work their way down to bit 0.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         data <= INIT;
      end else if (i_en) begin
         data <= {i_d, data[LEN-1:1]};
      end
   end

   assign o_q   = data[0];
   assign o_par = data[LEN-1:1];

endmodule

/* verilog/serv_ctrl.sv */
`timescale 1ns/1ps

module serv_ctrl import serv_cfg_pkg::*; import serv_seq_pkg::*; (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_en,
   input  logic            i_pc_en,
   input  logic            i_cnt_done,
   input  logic            i_jump,
   input  logic            i_offset,
   input  logic            i_rs1,
   input  logic            i_jalr,
   input  logic            i_auipc,
   input  logic            i_lui,
   input  logic            i_trap,
   input  logic            i_csr_pc,
   input  logic            i_ibus_ack,
   output logic            o_rd,
   output logic            o_bad_pc,
   output logic            o_misalign,
   output logic            o_ibus_cyc,
   output logic [XLEN-1:0] o_ibus_adr
);

   logic pc;
   logic new_pc;
   logic plus_4;
   logic pc_plus_4;
   logic offset_a;
   logic pc_plus_offset;
   logic pc_plus_offset_aligned;
   logic misalign_sample;

   // bit k of each history is the enable delayed by k+1 cycles.
   logic [PLUS4_BIT:0]    pc_en_hist;
   logic [MISALIGN_BIT:0] en_hist;

   // ------------------------------------------------------------------------
   // program counter and pc+4
   // ------------------------------------------------------------------------

   shift_reg #(
      .LEN  (XLEN),
      .INIT (RESET_PC)
   ) i_pc_reg (
      .clk   (clk),
      .i_rst (i_rst),
      .i_en  (i_pc_en),
      .i_d   (new_pc),
      .o_q   (pc),
      .o_par (o_ibus_adr[XLEN-1:1])
   );

   assign o_ibus_adr[0] = pc;

   // the constant 4 is a single one at bit PLUS4_BIT of the pass.
   assign plus_4 = pc_en_hist[PLUS4_BIT-1] & ~pc_en_hist[PLUS4_BIT];

   ser_add i_add_pc_plus_4 (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (pc),
      .i_b   (plus_4),
      .i_clr (i_cnt_done),
      .o_q   (pc_plus_4)
   );

   // ------------------------------------------------------------------------
   // jump target
   // ------------------------------------------------------------------------

   assign offset_a = i_jalr ? i_rs1 : pc;

   ser_add i_add_pc_plus_offset (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (offset_a),
      .i_b   (i_offset),
      .i_clr (~i_en),
      .o_q   (pc_plus_offset)
   );

   // pc_en_hist[0] is low only during bit 0, which clears the lsb of a target.
   assign pc_plus_offset_aligned = pc_plus_offset & pc_en_hist[0];

   assign new_pc = i_trap ? (i_csr_pc & pc_en_hist[0]) :
                   i_jump ? pc_plus_offset_aligned : pc_plus_4;

   assign o_rd = i_lui ? i_offset :
                 i_auipc ? pc_plus_offset_aligned : pc_plus_4;

   assign o_bad_pc = pc_plus_offset;

   assign misalign_sample = en_hist[MISALIGN_BIT-1] & ~en_hist[MISALIGN_BIT];

   // ------------------------------------------------------------------------
   // enable history, misalignment and fetch request
   // ------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (i_rst) begin
         // pc-enable history starts high so that the reset pc is fetched.
         pc_en_hist    <= '0;
         pc_en_hist[0] <= 1'b1;
         en_hist       <= '0;
         o_misalign    <= 1'b0;
         o_ibus_cyc    <= 1'b0;
      end else begin
         pc_en_hist <= {pc_en_hist[PLUS4_BIT-1:0], i_pc_en};
         en_hist    <= {en_hist[MISALIGN_BIT-1:0], i_en};
         if (misalign_sample) begin
            o_misalign <= pc_plus_offset;
         end
         // the pc register is complete once pc-enable has fallen.
         if (pc_en_hist[0] && !i_pc_en) begin
            o_ibus_cyc <= 1'b1;
         end else if (o_ibus_cyc && i_ibus_ack) begin
            o_ibus_cyc <= 1'b0;
         end
      end
   end

   // a new pass must not shift the pc while a fetch is still outstanding.
   a_adr_stable : assert property (@(posedge clk) disable iff (i_rst)
      o_ibus_cyc |=> (!o_ibus_cyc || $stable(o_ibus_adr)))
      else $error("ibus address changed during fetch");

endmodule

/* verilog/serv_seq.sv */
`timescale 1ns/1ps

module serv_seq import serv_cfg_pkg::*; import serv_seq_pkg::*; (
   input  logic             clk,
   input  logic             i_rst,
   input  logic             i_start,
   output logic             o_en,
   output logic             o_pc_en,
   output logic             o_cnt_done,
   output logic [CNT_W-1:0] o_cnt
);

   logic last_bit;

   assign last_bit = (o_cnt == CNT_W'(LAST_CNT));

   // one pass is LAST_CNT+1 enabled cycles, counted from zero.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_en  <= 1'b0;
         o_cnt <= '0;
      end else if (i_start) begin
         o_en  <= 1'b1;
         o_cnt <= '0;
      end else if (o_en) begin
         o_cnt <= o_cnt + 1'b1;
         if (last_bit) begin
            o_en <= 1'b0;
         end
      end
   end

   // the pc is written on every bit of the pass.
   assign o_pc_en    = o_en;
   assign o_cnt_done = o_en & last_bit;

   a_no_start_busy : assert property (@(posedge clk) disable iff (i_rst)
      i_start |-> !o_en)
      else $error("start strobe while a pass is running");

endmodule

/* verilog/serv_operand_shifter.sv */
`timescale 1ns/1ps

module serv_operand_shifter import serv_cfg_pkg::*; (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_start,
   input  logic            i_en,
   input  logic [XLEN-1:0] i_offset,
   input  logic [XLEN-1:0] i_rs1,
   input  logic [XLEN-1:0] i_trap_vec,
   output logic            o_offset,
   output logic            o_rs1,
   output logic            o_csr_pc
);

   logic [XLEN-1:0] offset_q;
   logic [XLEN-1:0] rs1_q;
   logic [XLEN-1:0] trap_vec_q;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         offset_q   <= '0;
         rs1_q      <= '0;
         trap_vec_q <= '0;
      end else if (i_start) begin
         offset_q   <= i_offset;
         rs1_q      <= i_rs1;
         trap_vec_q <= i_trap_vec;
      end else if (i_en) begin
         // lsb first, one bit of each word per enabled cycle.
         offset_q   <= {1'b0, offset_q[XLEN-1:1]};
         rs1_q      <= {1'b0, rs1_q[XLEN-1:1]};
         trap_vec_q <= {1'b0, trap_vec_q[XLEN-1:1]};
      end
   end

   assign o_offset = offset_q[0];
   assign o_rs1    = rs1_q[0];
   assign o_csr_pc = trap_vec_q[0];

endmodule

/* verilog/serv_collect.sv */
`timescale 1ns/1ps

module serv_collect import serv_cfg_pkg::*; import serv_seq_pkg::*; (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_en,
   input  logic            i_cnt_done,
   input  logic            i_bit,
   output logic [XLEN-1:0] o_word,
   output logic            o_valid
);

   logic             last_r;
   logic [CNT_W-1:0] bit_cnt;

   // bits enter at the top, so the first bit ends up at bit 0.
   always_ff @(posedge clk) begin
      if (i_en) begin
         o_word <= {i_bit, o_word[XLEN-1:1]};
      end
   end

   // valid comes one cycle after the word is complete, in step with the fetch.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         last_r  <= 1'b0;
         o_valid <= 1'b0;
         bit_cnt <= '0;
      end else begin
         last_r  <= i_en & i_cnt_done;
         o_valid <= last_r;
         if (i_en) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   a_done_at_last : assert property (@(posedge clk) disable iff (i_rst)
      i_en |-> (i_cnt_done == (bit_cnt == CNT_W'(LAST_CNT))))
      else $error("count done out of step with collected bits");

endmodule

/* verilog/serv_pc_unit.sv */
`timescale 1ns/1ps

module serv_pc_unit import serv_cfg_pkg::*; (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_start,
   input  logic            i_jump,
   input  logic            i_jalr,
   input  logic            i_auipc,
   input  logic            i_lui,
   input  logic            i_trap,
   input  logic            i_ibus_ack,
   input  logic [XLEN-1:0] i_offset,
   input  logic [XLEN-1:0] i_rs1,
   input  logic [XLEN-1:0] i_trap_vec,
   output logic [XLEN-1:0] o_rd_data,
   output logic [XLEN-1:0] o_bad_adr,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_rd_valid,
   output logic            o_misalign,
   output logic            o_ibus_cyc
);

   logic en;
   logic pc_en;
   logic cnt_done;
   logic offset_bit;
   logic rs1_bit;
   logic csr_pc_bit;
   logic rd_bit;
   logic bad_pc_bit;

   serv_seq i_seq (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .o_en       (en),
      .o_pc_en    (pc_en),
      .o_cnt_done (cnt_done),
      .o_cnt      ()
   );

   serv_operand_shifter i_operands (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .i_en       (en),
      .i_offset   (i_offset),
      .i_rs1      (i_rs1),
      .i_trap_vec (i_trap_vec),
      .o_offset   (offset_bit),
      .o_rs1      (rs1_bit),
      .o_csr_pc   (csr_pc_bit)
   );

   // the decoded control bits are used live, the caller holds them for the pass.
   serv_ctrl i_ctrl (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_en       (en),
      .i_pc_en    (pc_en),
      .i_cnt_done (cnt_done),
      .i_jump     (i_jump),
      .i_offset   (offset_bit),
      .i_rs1      (rs1_bit),
      .i_jalr     (i_jalr),
      .i_auipc    (i_auipc),
      .i_lui      (i_lui),
      .i_trap     (i_trap),
      .i_csr_pc   (csr_pc_bit),
      .i_ibus_ack (i_ibus_ack),
      .o_rd       (rd_bit),
      .o_bad_pc   (bad_pc_bit),
      .o_misalign (o_misalign),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr)
   );

   serv_collect i_rd_collect (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_en       (en),
      .i_cnt_done (cnt_done),
      .i_bit      (rd_bit),
      .o_word     (o_rd_data),
      .o_valid    (o_rd_valid)
   );

   // same timing as the rd word, so its valid is not needed.
   serv_collect i_bad_collect (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_en       (en),
      .i_cnt_done (cnt_done),
      .i_bit      (bad_pc_bit),
      .o_word     (o_bad_adr),
      .o_valid    ()
   );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int HALF_PERIOD  = 2,
   parameter int RESET_CYCLES = 16
) (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD) o_clk = ~o_clk;
   end

   // reset is released on a falling edge, like every other DUT input.
   initial begin
      o_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst = 1'b0;
   end

endmodule

/* verif/tb_serv_pc_unit.sv */
`timescale 1ns/1ps

module tb_serv_pc_unit
   import serv_cfg_pkg::*;
();

   localparam int N_INSTR       = 200;
   localparam int RESET_CYCLES  = 16;
   localparam int SEED          = 63401;
   localparam int LATENCY       = 33;
   localparam int MAX_ACK_DELAY = 5;
   // one pass, the longest ack wait plus the ack cycle, and some handshake slack.
   localparam int TIMEOUT_CYCLES =
      N_INSTR * (LATENCY + MAX_ACK_DELAY + 1 + 4) + RESET_CYCLES + 100;

   logic            clk;
   logic            i_rst;
   logic            i_start;
   logic            i_jump;
   logic            i_jalr;
   logic            i_auipc;
   logic            i_lui;
   logic            i_trap;
   logic            i_ibus_ack;
   logic [XLEN-1:0] i_offset;
   logic [XLEN-1:0] i_rs1;
   logic [XLEN-1:0] i_trap_vec;
   logic [XLEN-1:0] o_rd_data;
   logic [XLEN-1:0] o_bad_adr;
   logic [XLEN-1:0] o_ibus_adr;
   logic            o_rd_valid;
   logic            o_misalign;
   logic            o_ibus_cyc;

   logic [XLEN-1:0] model_pc;
   int              cycle_cnt = 0;

   tb_clk_gen #(
      .HALF_PERIOD  (2),
      .RESET_CYCLES (RESET_CYCLES)
   ) i_clk_gen (
      .o_clk (clk),
      .o_rst (i_rst)
   );

   serv_pc_unit i_serv_pc_unit (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .i_jump     (i_jump),
      .i_jalr     (i_jalr),
      .i_auipc    (i_auipc),
      .i_lui      (i_lui),
      .i_trap     (i_trap),
      .i_ibus_ack (i_ibus_ack),
      .i_offset   (i_offset),
      .i_rs1      (i_rs1),
      .i_trap_vec (i_trap_vec),
      .o_rd_data  (o_rd_data),
      .o_bad_adr  (o_bad_adr),
      .o_ibus_adr (o_ibus_adr),
      .o_rd_valid (o_rd_valid),
      .o_misalign (o_misalign),
      .o_ibus_cyc (o_ibus_cyc)
   );

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
         $display("test failed");
         $fatal(1);
      end
   end

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------

   task automatic value_error(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
      $display("** Error at time %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
      assert (act === exp) else begin
         value_error(name, exp, act);
      end
   endtask

   // the request must hold its address until the ack cycle and drop after it.
   task automatic complete_fetch(input logic [XLEN-1:0] exp_adr);
      int delay;
      delay = $urandom_range(MAX_ACK_DELAY, 0);
      check_word("o_ibus_cyc", 32'd1, XLEN'(o_ibus_cyc));
      check_word("o_ibus_adr", exp_adr, o_ibus_adr);
      repeat (delay) begin
         @(negedge clk);
         check_word("o_ibus_cyc", 32'd1, XLEN'(o_ibus_cyc));
         check_word("o_ibus_adr", exp_adr, o_ibus_adr);
         check_word("o_rd_valid", 32'd0, XLEN'(o_rd_valid));
      end
      i_ibus_ack = 1'b1;
      @(negedge clk);
      i_ibus_ack = 1'b0;
      check_word("o_ibus_cyc", 32'd0, XLEN'(o_ibus_cyc));
      check_word("o_rd_valid", 32'd0, XLEN'(o_rd_valid));
   endtask

   // ------------------------------------------------------------------------
   // one random instruction
   // ------------------------------------------------------------------------

   task automatic run_instr();
      logic [XLEN-1:0] offset;
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] trap_vec;
      logic [XLEN-1:0] target;
      logic [XLEN-1:0] exp_rd;
      logic [XLEN-1:0] exp_next;
      int              kind;
      int              wait_cnt;

      // 0 sequential, 1 jump, 2 lui, 3 auipc, 4 trap.
      kind     = $urandom_range(4, 0);
      offset   = $urandom;
      rs1      = $urandom;
      trap_vec = $urandom;

      i_jump     = (kind == 1);
      i_jalr     = (kind == 1) && ($urandom_range(1, 0) == 1);
      i_lui      = (kind == 2);
      i_auipc    = (kind == 3);
      i_trap     = (kind == 4);
      i_offset   = offset;
      i_rs1      = rs1;
      i_trap_vec = trap_vec;
      i_start    = 1'b1;

      target = (i_jalr ? rs1 : model_pc) + offset;
      if (i_lui) begin
         exp_rd = offset;
      end else if (i_auipc) begin
         exp_rd = (model_pc + offset) & ~32'd1;
      end else begin
         exp_rd = model_pc + 32'd4;
      end
      if (i_trap) begin
         exp_next = trap_vec & ~32'd1;
      end else if (i_jump) begin
         exp_next = target & ~32'd1;
      end else begin
         exp_next = model_pc + 32'd4;
      end

      @(negedge clk);
      i_start  = 1'b0;
      wait_cnt = 0;
      while (!o_rd_valid) begin
         @(negedge clk);
         wait_cnt++;
      end

      check_word("o_rd_valid latency", XLEN'(LATENCY), XLEN'(wait_cnt));
      check_word("o_rd_data", exp_rd, o_rd_data);
      check_word("o_bad_adr", target, o_bad_adr);
      check_word("o_misalign", XLEN'(target[1]), XLEN'(o_misalign));
      complete_fetch(exp_next);
      model_pc = exp_next;
   endtask

   initial begin
      i_start    = 1'b0;
      i_jump     = 1'b0;
      i_jalr     = 1'b0;
      i_auipc    = 1'b0;
      i_lui      = 1'b0;
      i_trap     = 1'b0;
      i_ibus_ack = 1'b0;
      i_offset   = '0;
      i_rs1      = '0;
      i_trap_vec = '0;
      void'($urandom(SEED));
      model_pc = RESET_PC;

      @(posedge clk);
      while (i_rst) begin
         @(negedge clk);
         check_word("o_ibus_cyc", 32'd0, XLEN'(o_ibus_cyc));
         check_word("o_rd_valid", 32'd0, XLEN'(o_rd_valid));
         @(posedge clk);
      end

      // the first edge out of reset starts the fetch of the reset pc, without any pass.
      @(negedge clk);
      complete_fetch(RESET_PC);

      for (int n = 0; n < N_INSTR; n++) begin
         run_instr();
      end

      $display("test passed");
      $finish;
   end

endmodule

/* serv_pc_unit.f */
verilog/serv_cfg_pkg.sv
verilog/serv_seq_pkg.sv
verilog/ser_add.sv
verilog/shift_reg.sv
verilog/serv_ctrl.sv
verilog/serv_seq.sv
verilog/serv_operand_shifter.sv
verilog/serv_collect.sv
verilog/serv_pc_unit.sv
verif/tb_clk_gen.sv
verif/tb_serv_pc_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f serv_pc_unit.f \
   --top-module tb_serv_pc_unit -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "test passed"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
